// ==== Bender.yml ====
package:
  name: credit_link

sources:
  - verilog/credit_link_pkg.sv
  - verilog/credit_counter.sv
  - verilog/credit_sender.sv
  - verilog/link_delay_line.sv
  - verilog/credit_receiver_fifo.sv
  - verilog/credit_link_top.sv
  - target: test
    files:
      - test/credit_link_tb.sv

// ==== test/credit_link_tb.sv ====
// --------------------------------------
// Credit link testbench
// Random traffic through the whole link,
// with a flit queue as reference model,
// full-buffer back-pressure, drain and
// single-flit latency checks
// --------------------------------------

`timescale 1ns/1ps

module credit_link_tb
  import credit_link_pkg::*;
();

  // --------------------------------------
  // Run limits
  // --------------------------------------

  localparam int RandomCycles   = 400;
  localparam int PendingTimeout = 64;
  localparam int DrainTimeout   = 200;
  localparam int FillTimeout    = 64;
  localparam int HoldCycles     = 20;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  flit_t   in_flit;
  logic    out_valid;
  logic    out_ready;
  flit_t   out_flit;
  credit_t credits_available;

  integer  seed;
  int      mismatch_count = 0;
  int      fail_count = 0;
  // Accepted flits still owed to the sink, oldest first
  flit_t   sent_q[$];

  credit_link_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid          (in_valid),
    .in_ready          (in_ready),
    .in_flit           (in_flit),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_flit          (out_flit),
    .credits_available (credits_available)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Link keeps order and payload, so the next pop owes the oldest accept
  function automatic flit_t expected_flit();
    flit_t head;
    head = sent_q.pop_front();
    return head;
  endfunction

  // --------------------------------------
  // Comparing process
  // --------------------------------------

  // Sampled on the rising edge, before any flop or stimulus update lands
  always @(posedge clk) begin : compare
    flit_t want;
    if (rst_n) begin
      assert (credits_available <= credit_t'(MaxCredits)) else begin
        mismatch_count++;
        $display("Mismatch at %0t: credits_available %0d, above the buffer depth %0d",
                 $time, credits_available, MaxCredits);
      end
      if (out_valid && out_ready) begin
        assert (sent_q.size() > 0) else begin
          fail_count++;
          $display("Sink popped a flit that was never accepted at %0t", $time);
        end
        if (sent_q.size() > 0) begin
          want = expected_flit();
          assert (out_flit == want) else begin
            mismatch_count++;
            $display("Mismatch at %0t: out_flit %h, expected %h", $time, out_flit, want);
          end
        end
      end
      // Pop first, a flit cannot leave on its own accepting edge
      if (in_valid && in_ready) begin
        sent_q.push_back(in_flit);
      end
    end
  end

  // --------------------------------------
  // Wait helpers
  // --------------------------------------

  // Hold the current flit until the sender takes it
  task automatic finish_pending_flit();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < PendingTimeout) begin
      @(posedge clk);
      waited++;
      // Nothing pending, or taken on this edge
      if (!in_valid || in_ready) begin
        in_valid <= 1'b0;
        done = 1'b1;
      end
    end
    assert (done) else begin
      fail_count++;
      $display("Timeout: pending source flit was never accepted");
    end
  endtask

  // Idle once every credit is home and the buffer is empty
  task automatic wait_for_drain(input string phase);
    int   waited;
    logic idle;
    waited = 0;
    idle   = 1'b0;
    while (!idle && waited < DrainTimeout) begin
      @(posedge clk);
      waited++;
      idle = (credits_available == credit_t'(MaxCredits)) && !out_valid;
    end
    assert (idle) else begin
      fail_count++;
      $display("Timeout: link did not drain after %s", phase);
    end
    @(negedge clk);
    assert (sent_q.size() == 0) else begin
      fail_count++;
      $display("%0d accepted flits never reached the sink after %s", sent_q.size(), phase);
    end
  endtask

  // --------------------------------------
  // Stimulus
  // --------------------------------------

  initial begin : stimulus
    int   accepts;
    int   waited;
    int   lat;
    logic seen;
    seed      = 32'h4309b6fc;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_flit   = '0;
    out_ready = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    @(posedge clk);
    assert (!out_valid && in_ready && credits_available == credit_t'(MaxCredits)) else begin
      mismatch_count++;
      $display("Mismatch at %0t: after reset out_valid %b in_ready %b credits %0d",
               $time, out_valid, in_ready, credits_available);
    end

    // Random traffic, a waiting flit stays put until accepted
    for (int c = 0; c < RandomCycles; c++) begin
      if (!in_valid || in_ready) begin
        in_valid <= ($random(seed) & 3) != 0;
        in_flit  <= flit_t'($random(seed));
      end
      out_ready <= ($random(seed) & 1) != 0;
      @(posedge clk);
    end
    out_ready <= 1'b1;
    finish_pending_flit();
    wait_for_drain("random traffic");

    // Stalled sink, source keeps pushing
    @(posedge clk);
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    in_flit   <= flit_t'($random(seed));
    accepts = 0;
    waited  = 0;
    while (accepts < MaxCredits && waited < FillTimeout) begin
      @(posedge clk);
      waited++;
      if (in_valid && in_ready) begin
        accepts++;
        in_flit <= flit_t'($random(seed));
      end
    end
    assert (accepts == MaxCredits) else begin
      fail_count++;
      $display("Timeout: only %0d flits accepted into the stalled link", accepts);
    end
    // Pool is empty now, so in_ready has to stay low
    repeat (HoldCycles) begin
      @(posedge clk);
      assert (!in_ready && credits_available == '0) else begin
        mismatch_count++;
        $display("Mismatch at %0t: in_ready %b credits %0d with a full buffer, expected 0 0",
                 $time, in_ready, credits_available);
      end
    end

    // Release the sink and let the waiting flit through
    out_ready <= 1'b1;
    finish_pending_flit();
    wait_for_drain("back-pressure release");

    // Single flit on an empty link
    @(posedge clk);
    in_valid <= 1'b1;
    in_flit  <= flit_t'($random(seed));
    finish_pending_flit();
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < PendingTimeout) begin
      @(posedge clk);
      lat++;
      seen = out_valid;
    end
    assert (seen) else begin
      fail_count++;
      $display("Timeout: single flit never reached out_valid");
    end
    // First sampled high LinkLatency+1 edges after the accepting edge
    assert (!seen || lat == LinkLatency + 1) else begin
      mismatch_count++;
      $display("Mismatch at %0t: flit latency %0d cycles, expected %0d",
               $time, lat, LinkLatency + 1);
    end
    wait_for_drain("single flit");

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : credit_link_tb

// ==== verilog.f ====
verilog/credit_link_pkg.sv
verilog/credit_counter.sv
verilog/credit_sender.sv
verilog/link_delay_line.sv
verilog/credit_receiver_fifo.sv
verilog/credit_link_top.sv
test/credit_link_tb.sv

// ==== verilog/credit_counter.sv ====
// --------------------------------------
// Credit counter
// Pool register that adds returned credits
// and subtracts spent ones in one cycle,
// with a look-ahead copy of the next value
// --------------------------------------

`timescale 1ns/1ps

module credit_counter
  import credit_link_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // One credit comes back to the pool
  input  logic    incr,
  // One credit is spent
  input  logic    decr,
  // Current pool
  output credit_t value,
  // Pool after this cycle's changes
  output credit_t value_next
);

  // --------------------------------------
  // Next value
  // --------------------------------------

  // Incr and decr together cancel out
  always_comb begin
    value_next = value;
    if (incr) begin
      value_next = value_next + credit_t'(1);
    end
    if (decr) begin
      value_next = value_next - credit_t'(1);
    end
  end

  // --------------------------------------
  // Pool register
  // --------------------------------------

  // Full pool out of reset, matching an empty receiver buffer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= credit_t'(MaxCredits);
    end else begin
      value <= value_next;
    end
  end

endmodule : credit_counter

// ==== verilog/credit_link_pkg.sv ====
// --------------------------------------
// Credit link shared definitions
// Link sizing, flit payload and credit
// count types used by every stage
// --------------------------------------

package credit_link_pkg;

  // --------------------------------------
  // Link sizing
  // --------------------------------------

  // Payload bits carried by one flit
  localparam int DataWidth = 16;

  // Receiver buffer depth, also the initial and maximum credit pool
  localparam int MaxCredits = 4;

  // Register stages in each direction of the link
  localparam int LinkLatency = 2;

  // Enough bits to hold 0 through MaxCredits inclusive
  localparam int CreditWidth = $clog2(MaxCredits + 1);

  // Index into the receiver buffer
  localparam int PtrWidth = (MaxCredits > 1) ? $clog2(MaxCredits) : 1;

  // --------------------------------------
  // Types
  // --------------------------------------

  // One flit payload
  typedef logic [DataWidth-1:0] flit_t;

  // Credit count, sender pool or buffer occupancy
  typedef logic [CreditWidth-1:0] credit_t;

  // Receiver buffer slot index
  typedef logic [PtrWidth-1:0] ptr_t;

endpackage : credit_link_pkg

// ==== verilog/credit_link_top.sv ====
// --------------------------------------
// Credit link top
// Sender, link pipeline and receiver
// buffer chained into one flit link
// --------------------------------------

`timescale 1ns/1ps

module credit_link_top
  import credit_link_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Source side
  input  logic    in_valid,
  output logic    in_ready,
  input  flit_t   in_flit,
  // Sink side
  output logic    out_valid,
  input  logic    out_ready,
  output flit_t   out_flit,
  // Sender pool
  output credit_t credits_available
);

  // Forward link
  logic  tx_flit_valid;
  flit_t tx_flit;
  logic  rx_flit_valid;
  flit_t rx_flit;

  // Backward link
  logic  credit_return;
  logic  credit_arrive;

  credit_sender credit_sender_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid          (in_valid),
    .in_ready          (in_ready),
    .in_flit           (in_flit),
    .credit_arrive     (credit_arrive),
    .tx_flit_valid     (tx_flit_valid),
    .tx_flit           (tx_flit),
    .credits_available (credits_available)
  );

  link_delay_line link_delay_line_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_flit_valid (tx_flit_valid),
    .tx_flit       (tx_flit),
    .rx_flit_valid (rx_flit_valid),
    .rx_flit       (rx_flit),
    .credit_return (credit_return),
    .credit_arrive (credit_arrive)
  );

  credit_receiver_fifo credit_receiver_fifo_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_flit_valid (rx_flit_valid),
    .rx_flit       (rx_flit),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_flit      (out_flit),
    .credit_return (credit_return)
  );

endmodule : credit_link_top

// ==== verilog/credit_receiver_fifo.sv ====
// --------------------------------------
// Credit receiver FIFO
// Buffers link flits for the sink and
// returns one credit for every pop
// --------------------------------------

`timescale 1ns/1ps

module credit_receiver_fifo
  import credit_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // Arriving flits, no back-pressure
  input  logic  rx_flit_valid,
  input  flit_t rx_flit,
  // Sink handshake
  output logic  out_valid,
  input  logic  out_ready,
  output flit_t out_flit,
  // One credit back per freed slot
  output logic  credit_return
);

  flit_t   mem [MaxCredits];
  ptr_t    wr_ptr;
  ptr_t    rd_ptr;
  credit_t count;
  logic    push;
  logic    pop;

  // Step a pointer around the ring
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    if (ptr == ptr_t'(MaxCredits - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  // A held credit guarantees a free slot for every push
  assign push = rx_flit_valid;
  assign pop  = out_valid && out_ready;

  // --------------------------------------
  // Storage
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_flit;
    end
  end

  // Oldest entry faces the sink
  assign out_flit  = mem[rd_ptr];
  assign out_valid = (count != '0);

  // --------------------------------------
  // Pointers, occupancy and credit pulse
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Push and pop together keep the count
      if (push && !pop) begin
        count <= count + credit_t'(1);
      end else if (pop && !push) begin
        count <= count - credit_t'(1);
      end
      // Credit leaves the cycle after the slot frees
      credit_return <= pop;
    end
  end

endmodule : credit_receiver_fifo

// ==== verilog/credit_sender.sv ====
// --------------------------------------
// Credit sender
// Accepts source flits only while a credit
// is held and launches them onto the link
// --------------------------------------

`timescale 1ns/1ps

module credit_sender
  import credit_link_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Source handshake
  input  logic    in_valid,
  output logic    in_ready,
  input  flit_t   in_flit,
  // Credit pulse from the link
  input  logic    credit_arrive,
  // Forward link, valid only
  output logic    tx_flit_valid,
  output flit_t   tx_flit,
  // Current pool for status
  output credit_t credits_available
);

  logic    accept;
  credit_t pool_next;
  logic    ready_q;

  // Handshake completes this cycle
  assign accept = in_valid && in_ready;

  // Pool spends on accept, refills on each arriving credit
  credit_counter credit_counter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .incr       (credit_arrive),
    .decr       (accept),
    .value      (credits_available),
    .value_next (pool_next)
  );

  // Ready comes straight from a flop
  // Tracks value != 0 one edge ahead via the look-ahead output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_q <= 1'b1;
    end else begin
      ready_q <= (pool_next != '0);
    end
  end

  assign in_ready = ready_q;

  // Launch in the accepting cycle
  assign tx_flit_valid = accept;
  assign tx_flit       = in_flit;

endmodule : credit_sender

// ==== verilog/link_delay_line.sv ====
// --------------------------------------
// Link delay line
// Fixed-latency model of the long wire,
// flits forward and credits backward
// --------------------------------------

`timescale 1ns/1ps

module link_delay_line
  import credit_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // Forward direction
  input  logic  tx_flit_valid,
  input  flit_t tx_flit,
  output logic  rx_flit_valid,
  output flit_t rx_flit,
  // Backward direction
  input  logic  credit_return,
  output logic  credit_arrive
);

  // Stage 0 is nearest the launching side
  logic [LinkLatency-1:0] fwd_valid;
  flit_t                  fwd_flit [LinkLatency];
  logic [LinkLatency-1:0] bwd_valid;

  // --------------------------------------
  // Valid pipelines
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fwd_valid <= '0;
      bwd_valid <= '0;
    end else begin
      fwd_valid[0] <= tx_flit_valid;
      bwd_valid[0] <= credit_return;
      for (int i = 1; i < LinkLatency; i++) begin
        fwd_valid[i] <= fwd_valid[i-1];
        bwd_valid[i] <= bwd_valid[i-1];
      end
    end
  end

  // Payload moves only behind a valid bit, idle stages hold
  always_ff @(posedge clk) begin
    if (tx_flit_valid) begin
      fwd_flit[0] <= tx_flit;
    end
    for (int i = 1; i < LinkLatency; i++) begin
      if (fwd_valid[i-1]) begin
        fwd_flit[i] <= fwd_flit[i-1];
      end
    end
  end

  // Far end of each pipeline
  assign rx_flit_valid = fwd_valid[LinkLatency-1];
  assign rx_flit       = fwd_flit[LinkLatency-1];
  assign credit_arrive = bwd_valid[LinkLatency-1];

endmodule : link_delay_line
